// File: verilog/rv32i_pkg.sv
package rv32i_pkg;

  ////////////////////////////////////////
  // Widths and basic types
  ////////////////////////////////////////

  localparam int XLEN     = 32;
  localparam int REG_BITS = 5;
  localparam int NUM_REGS = 2 ** REG_BITS;

  typedef logic [XLEN-1:0]     xlen_t;
  typedef logic [REG_BITS-1:0] reg_addr_t;
  typedef logic [31:0]         instr_t;

  // First fetch after reset
  localparam xlen_t RESET_PC = 32'h0000_0000;
  // Byte distance between sequential fetches
  localparam xlen_t PC_STEP  = 32'd4;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Major opcodes handled by this core, anything else is a bubble
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    // LUI value and JAL link go straight through on b
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // Branch funct3 field
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_e;

endpackage

// File: verilog/rv32i_alu.sv
module rv32i_alu import rv32i_pkg::*; (
  input  alu_op_e op_i,
  input  xlen_t   a_i,
  input  xlen_t   b_i,
  output xlen_t   result_o,
  output logic    equal_o,
  output logic    less_o,
  output logic    less_signed_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  ////////////////////////////////////////
  // Comparison flags
  ////////////////////////////////////////

  // Independent of op_i, used by branches and SLT/SLTU
  assign equal_o       = (a_i == b_i);
  assign less_o        = (a_i < b_i);
  assign less_signed_o = ($signed(a_i) < $signed(b_i));

  ////////////////////////////////////////
  // Result
  ////////////////////////////////////////

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, less_signed_o};
      ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, less_o};
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = xlen_t'($signed(a_i) >>> shamt);
      ALU_OR:     result_o = a_i | b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

endmodule

// File: verilog/rv32i_registers.sv
module rv32i_registers import rv32i_pkg::*; (
  input  logic      clk_i,
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  input  reg_addr_t rd_addr_i,
  input  logic      we_i,
  input  xlen_t     rd_data_i,
  output xlen_t     rs1_data_o,
  output xlen_t     rs2_data_o
);

  // x0 has no storage
  xlen_t regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (we_i && (rd_addr_i != '0)) begin
      regs_q[rd_addr_i] <= rd_data_i;
    end
  end

  // Write-through so a same-cycle reader sees the new value
  always_comb begin
    if (rs1_addr_i == '0) begin
      rs1_data_o = '0;
    end else if (we_i && (rd_addr_i == rs1_addr_i)) begin
      rs1_data_o = rd_data_i;
    end else begin
      rs1_data_o = regs_q[rs1_addr_i];
    end
  end

  always_comb begin
    if (rs2_addr_i == '0) begin
      rs2_data_o = '0;
    end else if (we_i && (rd_addr_i == rs2_addr_i)) begin
      rs2_data_o = rd_data_i;
    end else begin
      rs2_data_o = regs_q[rs2_addr_i];
    end
  end

  // Writeback stage filters rd 0 before it reaches the port
  a_no_x0_write : assert property (
    @(posedge clk_i) !(we_i && (rd_addr_i == '0))
  ) else $error("register write with rd x0");

endmodule

// File: verilog/rv32i_fetch.sv
module rv32i_fetch import rv32i_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  jal_taken_i,
  input  xlen_t jal_target_i,
  input  logic  br_taken_i,
  input  xlen_t br_target_i,
  output xlen_t imem_addr_o,
  output xlen_t fetch_pc_o,
  output logic  fetch_valid_o
);

  xlen_t pc_q;
  xlen_t pc_next;
  xlen_t inflight_pc_q;
  logic  inflight_valid_q;

  // Branch from execute is older than a JAL in decode
  always_comb begin
    if (br_taken_i) begin
      pc_next = br_target_i;
    end else if (jal_taken_i) begin
      pc_next = jal_target_i;
    end else begin
      pc_next = pc_q + PC_STEP;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q             <= RESET_PC;
      inflight_valid_q <= 1'b0;
    end else begin
      pc_q             <= pc_next;
      // Word already requested is stale once a redirect lands
      inflight_valid_q <= !(br_taken_i || jal_taken_i);
    end
  end

  // Address of the word coming back this cycle
  always_ff @(posedge clk_i) begin
    inflight_pc_q <= pc_q;
  end

  assign imem_addr_o   = pc_q;
  assign fetch_pc_o    = inflight_pc_q;
  assign fetch_valid_o = inflight_valid_q;

  // Redirect targets from decode and execute must keep fetch word aligned
  a_imem_addr_aligned : assert property (
    @(posedge clk_i) disable iff (reset_i) imem_addr_o[1:0] == 2'b00
  ) else $error("fetch address %h not word aligned", imem_addr_o);

endmodule

// File: verilog/rv32i_decode.sv
module rv32i_decode import rv32i_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      fetch_valid_i,
  input  logic      flush_i,
  input  instr_t    instr_i,
  input  xlen_t     pc_i,
  output logic      dec_valid_o,
  output alu_op_e   alu_op_o,
  output logic      use_imm_o,
  output logic      is_branch_o,
  output branch_e   branch_cond_o,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output reg_addr_t rd_o,
  output xlen_t     imm_o,
  output xlen_t     pc_o,
  output logic      jal_taken_o,
  output xlen_t     jal_target_o
);

  opcode_e   opcode;
  logic [2:0] funct3;
  logic      alt_bit;
  xlen_t     imm_i_type;
  xlen_t     imm_u_type;
  xlen_t     imm_b_type;
  xlen_t     imm_j_type;

  alu_op_e   alu_op_d;
  logic      use_imm_d;
  logic      is_branch_d;
  reg_addr_t rs1_d;
  reg_addr_t rs2_d;
  reg_addr_t rd_d;
  xlen_t     imm_d;

  // funct3 plus instr[30] selects the operation
  function automatic alu_op_e funct_to_op(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  funct_to_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  funct_to_op = ALU_SLL;
      3'b010:  funct_to_op = ALU_SLT;
      3'b011:  funct_to_op = ALU_SLTU;
      3'b100:  funct_to_op = ALU_XOR;
      3'b101:  funct_to_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  funct_to_op = ALU_OR;
      default: funct_to_op = ALU_AND;
    endcase
  endfunction

  ////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////

  assign opcode  = opcode_e'(instr_i[6:0]);
  assign funct3  = instr_i[14:12];
  assign alt_bit = instr_i[30];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    alu_op_d    = ALU_ADD;
    use_imm_d   = 1'b0;
    is_branch_d = 1'b0;
    rs1_d       = instr_i[19:15];
    rs2_d       = instr_i[24:20];
    rd_d        = '0;
    imm_d       = imm_i_type;
    case (opcode)
      OPC_OP: begin
        alu_op_d = funct_to_op(funct3, alt_bit);
        rd_d     = instr_i[11:7];
      end
      OPC_OP_IMM: begin
        // ADDI has no SUB form, bit 30 only matters for SRAI
        alu_op_d  = funct_to_op(funct3, (funct3 == 3'b101) && alt_bit);
        use_imm_d = 1'b1;
        rs2_d     = '0;
        rd_d      = instr_i[11:7];
      end
      OPC_LUI: begin
        alu_op_d  = ALU_PASS_B;
        use_imm_d = 1'b1;
        rs1_d     = '0;
        rs2_d     = '0;
        rd_d      = instr_i[11:7];
        imm_d     = imm_u_type;
      end
      OPC_JAL: begin
        // Link value rides in the immediate
        alu_op_d  = ALU_PASS_B;
        use_imm_d = 1'b1;
        rs1_d     = '0;
        rs2_d     = '0;
        rd_d      = instr_i[11:7];
        imm_d     = pc_i + PC_STEP;
      end
      OPC_BRANCH: begin
        is_branch_d = 1'b1;
        imm_d       = imm_b_type;
      end
      default: begin
        rs1_d = '0;
        rs2_d = '0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= fetch_valid_i && !flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    alu_op_o      <= alu_op_d;
    use_imm_o     <= use_imm_d;
    is_branch_o   <= is_branch_d;
    branch_cond_o <= branch_e'(funct3);
    rs1_o         <= rs1_d;
    rs2_o         <= rs2_d;
    rd_o          <= rd_d;
    imm_o         <= imm_d;
    pc_o          <= pc_i;
  end

  // Early redirect, fetch gives a taken branch priority
  assign jal_taken_o  = fetch_valid_i && (opcode == OPC_JAL);
  assign jal_target_o = pc_i + imm_j_type;

endmodule

// File: verilog/rv32i_execute.sv
module rv32i_execute import rv32i_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      dec_valid_i,
  input  alu_op_e   alu_op_i,
  input  logic      use_imm_i,
  input  logic      is_branch_i,
  input  branch_e   branch_cond_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  reg_addr_t rd_i,
  input  xlen_t     imm_i,
  input  xlen_t     pc_i,
  output logic      br_taken_o,
  output xlen_t     br_target_o,
  output logic      wb_valid_o,
  output reg_addr_t wb_rd_o,
  output xlen_t     wb_data_o
);

  xlen_t     rf_rs1;
  xlen_t     rf_rs2;
  xlen_t     op_a;
  xlen_t     op_b;

  logic      ex_valid_q;
  alu_op_e   ex_alu_op_q;
  logic      ex_is_branch_q;
  branch_e   ex_cond_q;
  reg_addr_t ex_rd_q;
  xlen_t     ex_a_q;
  xlen_t     ex_b_q;
  xlen_t     ex_target_q;

  xlen_t     alu_result;
  logic      alu_equal;
  logic      alu_less;
  logic      alu_less_signed;
  logic      cond_met;

  logic      wb_valid_q;
  reg_addr_t wb_rd_q;
  xlen_t     wb_data_q;

  rv32i_registers u_rv32i_registers (
    .clk_i      (clk_i),
    .rs1_addr_i (rs1_i),
    .rs2_addr_i (rs2_i),
    .rd_addr_i  (wb_rd_q),
    .we_i       (wb_valid_q),
    .rd_data_i  (wb_data_q),
    .rs1_data_o (rf_rs1),
    .rs2_data_o (rf_rs2)
  );

  ////////////////////////////////////////
  // Operand fetch
  ////////////////////////////////////////

  // Execute result is younger than writeback, so it wins
  assign op_a = (ex_valid_q && (ex_rd_q != '0) && (ex_rd_q == rs1_i)) ? alu_result :
                (wb_valid_q && (wb_rd_q == rs1_i))                    ? wb_data_q  : rf_rs1;
  assign op_b = (ex_valid_q && (ex_rd_q != '0) && (ex_rd_q == rs2_i)) ? alu_result :
                (wb_valid_q && (wb_rd_q == rs2_i))                    ? wb_data_q  : rf_rs2;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_valid_q <= 1'b0;
    end else begin
      // Taken branch squashes the instruction behind it
      ex_valid_q <= dec_valid_i && !br_taken_o;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_alu_op_q    <= alu_op_i;
    ex_is_branch_q <= is_branch_i;
    ex_cond_q      <= branch_cond_i;
    ex_rd_q        <= rd_i;
    ex_a_q         <= op_a;
    ex_b_q         <= use_imm_i ? imm_i : op_b;
    ex_target_q    <= pc_i + imm_i;
  end

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////

  rv32i_alu u_rv32i_alu (
    .op_i          (ex_alu_op_q),
    .a_i           (ex_a_q),
    .b_i           (ex_b_q),
    .result_o      (alu_result),
    .equal_o       (alu_equal),
    .less_o        (alu_less),
    .less_signed_o (alu_less_signed)
  );

  always_comb begin
    case (ex_cond_q)
      BR_EQ:   cond_met = alu_equal;
      BR_NE:   cond_met = !alu_equal;
      BR_LT:   cond_met = alu_less_signed;
      BR_GE:   cond_met = !alu_less_signed;
      BR_LTU:  cond_met = alu_less;
      BR_GEU:  cond_met = !alu_less;
      default: cond_met = 1'b0;
    endcase
  end

  assign br_taken_o  = ex_valid_q && ex_is_branch_q && cond_met;
  assign br_target_o = ex_target_q;

  ////////////////////////////////////////
  // Writeback
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_q <= 1'b0;
    end else begin
      // Branches and bubbles carry rd 0
      wb_valid_q <= ex_valid_q && (ex_rd_q != '0);
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_q   <= ex_rd_q;
    wb_data_q <= alu_result;
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_rd_o    = wb_rd_q;
  assign wb_data_o  = wb_data_q;

  // A live branch in execute comes from decode without a destination
  a_branch_no_rd : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (ex_valid_q && ex_is_branch_q) |-> (ex_rd_q == '0)
  ) else $error("branch in execute carries rd x%0d", ex_rd_q);

endmodule

// File: verilog/rv32i_pipe.sv
module rv32i_pipe import rv32i_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  output xlen_t     imem_addr_o,
  input  instr_t    imem_data_i,
  output logic      wb_valid_o,
  output reg_addr_t wb_rd_o,
  output xlen_t     wb_data_o
);

  // Fetch to decode
  logic      fetch_valid;
  xlen_t     fetch_pc;

  // Redirects
  logic      jal_taken;
  xlen_t     jal_target;
  logic      br_taken;
  xlen_t     br_target;

  // Decode to execute
  logic      dec_valid;
  alu_op_e   dec_alu_op;
  logic      dec_use_imm;
  logic      dec_is_branch;
  branch_e   dec_branch_cond;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  reg_addr_t dec_rd;
  xlen_t     dec_imm;
  xlen_t     dec_pc;

  rv32i_fetch u_rv32i_fetch (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .jal_taken_i   (jal_taken),
    .jal_target_i  (jal_target),
    .br_taken_i    (br_taken),
    .br_target_i   (br_target),
    .imem_addr_o   (imem_addr_o),
    .fetch_pc_o    (fetch_pc),
    .fetch_valid_o (fetch_valid)
  );

  rv32i_decode u_rv32i_decode (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_valid_i (fetch_valid),
    .flush_i       (br_taken),
    .instr_i       (imem_data_i),
    .pc_i          (fetch_pc),
    .dec_valid_o   (dec_valid),
    .alu_op_o      (dec_alu_op),
    .use_imm_o     (dec_use_imm),
    .is_branch_o   (dec_is_branch),
    .branch_cond_o (dec_branch_cond),
    .rs1_o         (dec_rs1),
    .rs2_o         (dec_rs2),
    .rd_o          (dec_rd),
    .imm_o         (dec_imm),
    .pc_o          (dec_pc),
    .jal_taken_o   (jal_taken),
    .jal_target_o  (jal_target)
  );

  rv32i_execute u_rv32i_execute (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .dec_valid_i   (dec_valid),
    .alu_op_i      (dec_alu_op),
    .use_imm_i     (dec_use_imm),
    .is_branch_i   (dec_is_branch),
    .branch_cond_i (dec_branch_cond),
    .rs1_i         (dec_rs1),
    .rs2_i         (dec_rs2),
    .rd_i          (dec_rd),
    .imm_i         (dec_imm),
    .pc_i          (dec_pc),
    .br_taken_o    (br_taken),
    .br_target_o   (br_target),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

endmodule

// File: verif/rv32i_pipe_tb.sv
module rv32i_pipe_tb import rv32i_pkg::*; ();

  localparam string  PATTERN_FILE   = "verif/rv32i_patterns.hex";
  localparam int     PATTERN_DEPTH  = 256;
  localparam int     TIMEOUT_FACTOR = 8;
  localparam int     TIMEOUT_SLACK  = 50;
  // Quiet cycles checked after the last expected writeback
  localparam int     DRAIN_CYCLES   = 12;
  localparam time    DRIVE_DELAY    = 1;
  // addi x0, x0, 0
  localparam instr_t NOP            = 32'h0000_0013;

  logic      clk;
  logic      reset;
  xlen_t     imem_addr;
  instr_t    imem_data;
  logic      wb_valid;
  reg_addr_t wb_rd;
  xlen_t     wb_data;

  // Count, program, count, pairs
  logic [31:0] patterns [0:PATTERN_DEPTH-1];
  int unsigned prog_words;
  int unsigned exp_count;
  int unsigned exp_base;
  int unsigned wb_count;
  int unsigned cycle_count;
  int unsigned cycle_limit;
  xlen_t       req_addr;

  rv32i_pipe i_rv32i_pipe (
    .clk_i       (clk),
    .reset_i     (reset),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .wb_valid_o  (wb_valid),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // Instruction memory model
  ////////////////////////////////////////

  function automatic instr_t fetch_word(xlen_t addr);
    xlen_t index;
    index = addr >> 2;
    if ($isunknown(addr) || (index >= prog_words)) begin
      return NOP;
    end
    return patterns[1 + index];
  endfunction

  // Word requested last cycle comes back this cycle
  always @(posedge clk) begin
    #DRIVE_DELAY;
    imem_data = fetch_word(req_addr);
    req_addr  = imem_addr;
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_rd(input reg_addr_t expected, input reg_addr_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t: writeback %0d rd expected x%0d, got x%0d",
               $time, wb_count, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_data(input xlen_t expected, input xlen_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t: writeback %0d data expected %h, got %h",
               $time, wb_count, expected, actual);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    reset       = 1'b1;
    imem_data   = NOP;
    req_addr    = RESET_PC;
    wb_count    = 0;
    cycle_count = 0;

    $readmemh(PATTERN_FILE, patterns);
    prog_words = patterns[0];
    if ($isunknown(patterns[0]) || (prog_words + 2 > PATTERN_DEPTH)) begin
      $display("Pattern file holds no usable program word count");
      abort_run();
    end
    exp_count = patterns[prog_words + 1];
    exp_base  = prog_words + 2;
    if ((exp_count == 0) || (exp_base + 2 * exp_count > PATTERN_DEPTH)) begin
      $display("Pattern file holds no usable writeback count");
      abort_run();
    end
    cycle_limit = TIMEOUT_FACTOR * (prog_words + exp_count) + TIMEOUT_SLACK;

    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;

    // Writeback ports are registered, so the falling edge sees them settled
    while (wb_count < exp_count) begin
      @(negedge clk);
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        $display("Timeout after %0d cycles, only %0d of %0d expected writebacks arrived",
                 cycle_count, wb_count, exp_count);
        abort_run();
      end
      if (wb_valid) begin
        check_rd(reg_addr_t'(patterns[exp_base + 2 * wb_count]), wb_rd);
        check_data(patterns[exp_base + 2 * wb_count + 1], wb_data);
        wb_count++;
      end
    end

    // Past the program only NOPs are fetched
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      if (wb_valid) begin
        $display("Unexpected writeback to x%0d with data %h after all %0d expected ones",
                 wb_rd, wb_data, exp_count);
        abort_run();
      end
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: verif/rv32i_patterns.hex
// Word count N, then N program words from address 0,
// then writeback count M and M pairs of rd and expected data
00000036
// Setup and register-register ops
00500093 FFD00113                     // addi x1,5  addi x2,-3
002081B3 40208233 003092B3 00112333   // add x3  sub x4  sll x5  slt x6
001133B3 0020C433 003154B3 40315533   // sltu x7  xor x8  srl x9  sra x10
0020E5B3 0020F633                     // or x11  and x12
// Immediate ops and LUI
800006B7 4046D713 0046D793 00309813   // lui x13  srai x14  srli x15  slli x16
FFE12893 7FF68913                     // slti x17  addi x18
// Dependent chain on x20 to x23 at distances 1 to 3
00100A13 002A0A13 014A0AB3 015A0B33 016A0BB3
// Write to x0, then read it at distances 1 and 2
00708013 00100C33 40008CB3
// Per condition: not taken by +8, taken by +8, skipped word, landing
00208463 00108463 FFF00F93 00100D13   // beq
00109463 00209463 FFF00F93 00200D13   // bne
0020C463 00114463 FFF00F93 00300D13   // blt
00115463 0020D463 FFF00F93 00400D13   // bge
00116463 0020E463 FFF00F93 00500D13   // bltu
0020F463 00117463 FFF00F93 00600D13   // bgeu
// jal x27 by +8 over one word, then uses of the link value
00800DEF FFF00F93 001D8E13 01BE0EB3
// Expected writebacks
00000022
01 00000005  02 FFFFFFFD  03 00000002  04 00000008
05 00000014  06 00000001  07 00000000  08 FFFFFFF8
09 3FFFFFFF  0A FFFFFFFF  0B FFFFFFFD  0C 00000005
0D 80000000  0E F8000000  0F 08000000  10 00000028
11 00000001  12 800007FF
14 00000001  14 00000003  15 00000006  16 00000009  17 0000000C
18 00000005  19 00000005
1A 00000001  1A 00000002  1A 00000003  1A 00000004  1A 00000005  1A 00000006
1B 000000CC  1C 000000CD  1D 00000199

// File: sim.f
verilog/rv32i_pkg.sv
verilog/rv32i_alu.sv
verilog/rv32i_registers.sv
verilog/rv32i_fetch.sv
verilog/rv32i_decode.sv
verilog/rv32i_execute.sv
verilog/rv32i_pipe.sv
verif/rv32i_pipe_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := rv32i_pipe_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
